//--- files.f
+incdir+source
source/operand_pkg.sv
source/reg_file.sv
source/forward_ctrl.sv
source/operand_muxes.sv
source/exec_unit.sv
source/operand_slice_top.sv
testbench/operand_slice_assertions.sv
testbench/operand_slice_tb.sv

//--- source/exec_unit.sv
// Execute unit
// Execute control register, ALU and writeback register.
// The writeback register drives both the forward path and the register
// file write port.
`timescale 1ns/1ps
`default_nettype none

`include "operand_settings.svh"

module exec_unit import operand_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	// Pipeline freeze levels
	input  logic                  id_freeze,
	input  logic                  ex_freeze,
	// Decode control
	input  logic                  id_valid,
	input  logic [`OP_REG_AW-1:0] id_rd,
	input  alu_op_t               id_alu_op,
	// Registered operands
	input  logic [`OP_WIDTH-1:0]  operand_a,
	input  logic [`OP_WIDTH-1:0]  operand_b,
	// Execute stage
	output logic [`OP_WIDTH-1:0]  ex_result,
	output logic [`OP_REG_AW-1:0] ex_rd,
	output logic                  ex_valid,
	// Writeback stage
	output logic [`OP_WIDTH-1:0]  wb_data,
	output logic [`OP_REG_AW-1:0] wb_rd,
	output logic                  wb_valid,
	output logic                  rf_we
);

	// Shift amount width follows the data width
	localparam int SHAMT_W = $clog2(`OP_WIDTH);

	alu_op_t              ex_alu_op;
	logic [SHAMT_W-1:0]   shamt;

	////////////////////////////////////////////////////////////////////////////
	// Execute control register

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_valid  <= 1'b0;
			ex_rd     <= '0;
			ex_alu_op <= ALU_ADD;
		end else if (!ex_freeze) begin
			if (id_freeze) begin
				// Decode held, insert a bubble
				ex_valid <= 1'b0;
			end else begin
				ex_valid  <= id_valid;
				ex_rd     <= id_rd;
				ex_alu_op <= id_alu_op;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// ALU

	assign shamt = operand_b[SHAMT_W-1:0];

	always_comb begin
		case (ex_alu_op)
			ALU_ADD: ex_result = operand_a + operand_b;
			ALU_SUB: ex_result = operand_a - operand_b;
			ALU_AND: ex_result = operand_a & operand_b;
			ALU_OR:  ex_result = operand_a | operand_b;
			ALU_XOR: ex_result = operand_a ^ operand_b;
			ALU_SLL: ex_result = operand_a << shamt;
			ALU_SRL: ex_result = operand_a >> shamt;
			default: ex_result = '0;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Writeback register

	// Control part, cleared by reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
			wb_rd    <= '0;
		end else if (!ex_freeze) begin
			wb_valid <= ex_valid;
			wb_rd    <= ex_rd;
		end
	end

	// Result payload
	always_ff @(posedge clk) begin
		if (!ex_freeze) begin
			wb_data <= ex_result;
		end
	end

	// No register file update while the back end is frozen
	assign rf_we = wb_valid & ~ex_freeze;

endmodule

`default_nettype wire

//--- source/forward_ctrl.sv
// Forwarding control
// Compares the decode source registers against the destinations held in
// execute and writeback and picks the source of each operand
`timescale 1ns/1ps
`default_nettype none

`include "operand_settings.svh"

module forward_ctrl import operand_pkg::*; (
	// Decode sources
	input  logic [`OP_REG_AW-1:0] id_rs_a,
	input  logic [`OP_REG_AW-1:0] id_rs_b,
	input  logic                  id_use_imm,
	// Execute stage destination
	input  logic [`OP_REG_AW-1:0] ex_rd,
	input  logic                  ex_valid,
	// Writeback stage destination
	input  logic [`OP_REG_AW-1:0] wb_rd,
	input  logic                  wb_valid,
	// Operand selects
	output operand_sel_t          sel_a,
	output operand_sel_t          sel_b
);

	// Hazard check for one source register
	// Execute holds the newer value and wins over writeback
	function automatic operand_sel_t fwd_sel(input logic [`OP_REG_AW-1:0] rs);
		operand_sel_t sel;
		sel = SEL_RF;
		// r0 is constant and never forwarded
		if (rs != '0) begin
			if (ex_valid && (rs == ex_rd)) begin
				sel = SEL_EX_FORW;
			end else if (wb_valid && (rs == wb_rd)) begin
				sel = SEL_WB_FORW;
			end
		end
		return sel;
	endfunction

	always_comb begin
		// Operand A always comes from a register
		sel_a = fwd_sel(id_rs_a);
		// Immediate overrides any hazard on B
		sel_b = id_use_imm ? SEL_IMM : fwd_sel(id_rs_b);
	end

endmodule

`default_nettype wire

//--- source/operand_muxes.sv
// Operand multiplexers
// Selects each operand from the register file, the forward paths or the
// immediate, and latches it into a freeze-aware operand register.
// On the first decode-only freeze edge the operand is captured once and
// then held, so a forwarded value survives while execute drains.
`timescale 1ns/1ps
`default_nettype none

`include "operand_settings.svh"

module operand_muxes import operand_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	// Pipeline freeze levels
	input  logic                 id_freeze,
	input  logic                 ex_freeze,
	// Candidate sources
	input  logic [`OP_WIDTH-1:0] rf_data_a,
	input  logic [`OP_WIDTH-1:0] rf_data_b,
	input  logic [`OP_WIDTH-1:0] ex_forw,
	input  logic [`OP_WIDTH-1:0] wb_forw,
	input  logic [`OP_WIDTH-1:0] simm,
	// Selects from forwarding control
	input  operand_sel_t         sel_a,
	input  operand_sel_t         sel_b,
	// Registered operands to execute
	output logic [`OP_WIDTH-1:0] operand_a,
	output logic [`OP_WIDTH-1:0] operand_b
);

	// Index 0 is operand A, index 1 is operand B
	logic [`OP_WIDTH-1:0] muxed   [2];
	logic [`OP_WIDTH-1:0] operand [2];
	logic                 saved   [2];

	////////////////////////////////////////////////////////////////////////////
	// Source multiplexers

	always_comb begin
		// A never sees the immediate
		case (sel_a)
			SEL_EX_FORW: muxed[0] = ex_forw;
			SEL_WB_FORW: muxed[0] = wb_forw;
			default:     muxed[0] = rf_data_a;
		endcase

		case (sel_b)
			SEL_IMM:     muxed[1] = simm;
			SEL_EX_FORW: muxed[1] = ex_forw;
			SEL_WB_FORW: muxed[1] = wb_forw;
			default:     muxed[1] = rf_data_b;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Operand registers

	for (genvar i = 0; i < 2; i++) begin : g_opreg
		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				operand[i] <= '0;
				saved[i]   <= 1'b0;
			end else if (!ex_freeze && !saved[i]) begin
				// Normal load, or the single capture at freeze entry
				operand[i] <= muxed[i];
				saved[i]   <= id_freeze;
			end else if (!ex_freeze && !id_freeze) begin
				// Release edge keeps the captured operand
				saved[i] <= 1'b0;
			end
		end
	end

	assign operand_a = operand[0];
	assign operand_b = operand[1];

endmodule

`default_nettype wire

//--- source/operand_pkg.sv
// Operand slice package
// ALU opcodes and operand source selects for the execute slice
`default_nettype none

package operand_pkg;

	// ALU operations, shifts take the low five bits of operand B
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLL = 3'd5,
		ALU_SRL = 3'd6
	} alu_op_t;

	// Where an operand register loads from
	// Immediate is only meaningful on operand B
	typedef enum logic [1:0] {
		SEL_RF      = 2'd0,
		SEL_IMM     = 2'd1,
		SEL_EX_FORW = 2'd2,
		SEL_WB_FORW = 2'd3
	} operand_sel_t;

endpackage

`default_nettype wire

//--- source/operand_settings.svh
// Operand slice settings
// Data width and register file geometry shared by every block of the
// operand-fetch and execute slice
`ifndef OPERAND_SETTINGS_SVH
`define OPERAND_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath

// Width of operands, results and register file entries
`define OP_WIDTH 32

// Number of general purpose registers, r0 reads as zero
`define OP_REG_COUNT 32

// Register number width
`define OP_REG_AW 5

`endif

//--- source/operand_slice_top.sv
// Operand slice top
// Register file, forwarding control, operand registers and execute unit
// of the operand-fetch and execute part of a five-stage pipeline
`timescale 1ns/1ps
`default_nettype none

`include "operand_settings.svh"

module operand_slice_top import operand_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	// Freeze levels, ex_freeze only with id_freeze
	input  logic                  id_freeze,
	input  logic                  ex_freeze,
	// Decoded instruction
	input  logic                  id_valid,
	input  logic [`OP_REG_AW-1:0] id_rs_a,
	input  logic [`OP_REG_AW-1:0] id_rs_b,
	input  logic [`OP_REG_AW-1:0] id_rd,
	input  logic [`OP_WIDTH-1:0]  id_imm,
	input  logic                  id_use_imm,
	input  alu_op_t               id_alu_op,
	// Writeback result
	output logic                  wb_valid,
	output logic [`OP_REG_AW-1:0] wb_rd,
	output logic [`OP_WIDTH-1:0]  wb_data
);

	// Register file read data
	logic [`OP_WIDTH-1:0]  rf_data_a;
	logic [`OP_WIDTH-1:0]  rf_data_b;
	// Operand selects
	operand_sel_t          sel_a;
	operand_sel_t          sel_b;
	// Registered operands
	logic [`OP_WIDTH-1:0]  operand_a;
	logic [`OP_WIDTH-1:0]  operand_b;
	// Execute stage, ex_result doubles as the execute forward path
	logic [`OP_WIDTH-1:0]  ex_result;
	logic [`OP_REG_AW-1:0] ex_rd;
	logic                  ex_valid;
	logic                  rf_we;

	reg_file u_reg_file (
		.clk       (clk),
		.rst_n     (rst_n),
		.rs_a      (id_rs_a),
		.rs_b      (id_rs_b),
		.we        (rf_we),
		.wr_addr   (wb_rd),
		.wr_data   (wb_data),
		.rd_data_a (rf_data_a),
		.rd_data_b (rf_data_b)
	);

	forward_ctrl u_forward_ctrl (
		.id_rs_a    (id_rs_a),
		.id_rs_b    (id_rs_b),
		.id_use_imm (id_use_imm),
		.ex_rd      (ex_rd),
		.ex_valid   (ex_valid),
		.wb_rd      (wb_rd),
		.wb_valid   (wb_valid),
		.sel_a      (sel_a),
		.sel_b      (sel_b)
	);

	operand_muxes u_operand_muxes (
		.clk       (clk),
		.rst_n     (rst_n),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.rf_data_a (rf_data_a),
		.rf_data_b (rf_data_b),
		.ex_forw   (ex_result),
		.wb_forw   (wb_data),
		.simm      (id_imm),
		.sel_a     (sel_a),
		.sel_b     (sel_b),
		.operand_a (operand_a),
		.operand_b (operand_b)
	);

	exec_unit u_exec_unit (
		.clk       (clk),
		.rst_n     (rst_n),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.id_valid  (id_valid),
		.id_rd     (id_rd),
		.id_alu_op (id_alu_op),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.ex_result (ex_result),
		.ex_rd     (ex_rd),
		.ex_valid  (ex_valid),
		.wb_data   (wb_data),
		.wb_rd     (wb_rd),
		.wb_valid  (wb_valid),
		.rf_we     (rf_we)
	);

endmodule

`default_nettype wire

//--- source/reg_file.sv
// Register file
// Two combinational read ports and one synchronous write port.
// Register 0 is hardwired to zero, writes to it are dropped.
`timescale 1ns/1ps
`default_nettype none

`include "operand_settings.svh"

module reg_file (
	input  logic                  clk,
	input  logic                  rst_n,
	// Read addresses from decode
	input  logic [`OP_REG_AW-1:0] rs_a,
	input  logic [`OP_REG_AW-1:0] rs_b,
	// Write port from writeback
	input  logic                  we,
	input  logic [`OP_REG_AW-1:0] wr_addr,
	input  logic [`OP_WIDTH-1:0]  wr_data,
	// Read data
	output logic [`OP_WIDTH-1:0]  rd_data_a,
	output logic [`OP_WIDTH-1:0]  rd_data_b
);

	// Storage array
	logic [`OP_WIDTH-1:0] regs [`OP_REG_COUNT];

	////////////////////////////////////////////////////////////////////////////
	// Write port

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			// All registers start out as zero
			for (int i = 0; i < `OP_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wr_addr != '0)) begin
			// r0 is never written
			regs[wr_addr] <= wr_data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read ports

	// Same-cycle write is not visible here
	// Writeback forwarding covers that case
	assign rd_data_a = (rs_a == '0) ? '0 : regs[rs_a];
	assign rd_data_b = (rs_b == '0) ? '0 : regs[rs_b];

endmodule

`default_nettype wire

//--- testbench/operand_slice_assertions.sv
// Operand slice assertions
// Freeze ordering, register file write gating and writeback behavior,
// bound to the slice top level
`timescale 1ns/1ps
`default_nettype none

`include "operand_settings.svh"

module operand_slice_assertions (
	input logic                 clk,
	input logic                 rst_n,
	input logic                 id_freeze,
	input logic                 ex_freeze,
	input logic                 wb_valid,
	// Register file entry addressed by writeback
	input logic [`OP_WIDTH-1:0] wb_entry
);

	// Count of failed assertions read by the testbench
	int fail_count = 0;

	// Back end freeze is always a subset of the decode freeze
	freeze_order: assert property (@(posedge clk) disable iff (!rst_n)
		ex_freeze |-> id_freeze)
		else begin
			fail_count++;
			$error("ex_freeze high while id_freeze is low");
		end

	// Frozen back end leaves the addressed register untouched
	no_frozen_write: assert property (@(posedge clk) disable iff (!rst_n)
		ex_freeze |=> $stable(wb_entry))
		else begin
			fail_count++;
			$error("register file write while ex_freeze is high");
		end

	// Nothing leaves writeback right after reset
	wb_idle_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> !wb_valid)
		else begin
			fail_count++;
			$error("wb_valid high in the first cycle after reset");
		end

	// Writeback register holds across a frozen edge
	wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
		ex_freeze |=> $stable(wb_valid))
		else begin
			fail_count++;
			$error("wb_valid changed across an ex_freeze cycle");
		end

endmodule

bind operand_slice_top operand_slice_assertions u_assertions (
	.clk       (clk),
	.rst_n     (rst_n),
	.id_freeze (id_freeze),
	.ex_freeze (ex_freeze),
	.wb_valid  (wb_valid),
	.wb_entry  (u_reg_file.regs[wb_rd])
);

`default_nettype wire

//--- testbench/operand_slice_tb.sv
// Operand slice testbench
// Directed tests for register file reads, ALU operations, both forward
// paths and the two freeze levels. A reference register model predicts
// every writeback in issue order.
`timescale 1ns/1ps
`default_nettype none

`include "operand_settings.svh"

module operand_slice_tb import operand_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 50;

	// DUT inputs
	logic                  clk;
	logic                  rst_n;
	logic                  id_freeze;
	logic                  ex_freeze;
	logic                  id_valid;
	logic [`OP_REG_AW-1:0] id_rs_a;
	logic [`OP_REG_AW-1:0] id_rs_b;
	logic [`OP_REG_AW-1:0] id_rd;
	logic [`OP_WIDTH-1:0]  id_imm;
	logic                  id_use_imm;
	alu_op_t               id_alu_op;
	// DUT outputs
	logic                  wb_valid;
	logic [`OP_REG_AW-1:0] wb_rd;
	logic [`OP_WIDTH-1:0]  wb_data;

	// Reference registers with r0 never written
	logic [`OP_WIDTH-1:0]  model_regs [`OP_REG_COUNT];
	// Expected writebacks, oldest first
	logic [`OP_REG_AW-1:0] exp_rd_q [$];
	logic [`OP_WIDTH-1:0]  exp_data_q [$];
	logic [`OP_REG_AW-1:0] exp_rd;
	logic [`OP_WIDTH-1:0]  exp_data;
	// Writeback register was loaded on the previous edge
	logic                  wb_new;
	int                    wb_seen;
	int                    errors;
	int                    tests_run;
	int                    tests_failing;
	integer                seed;

	operand_slice_top dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.id_freeze  (id_freeze),
		.ex_freeze  (ex_freeze),
		.id_valid   (id_valid),
		.id_rs_a    (id_rs_a),
		.id_rs_b    (id_rs_b),
		.id_rd      (id_rd),
		.id_imm     (id_imm),
		.id_use_imm (id_use_imm),
		.id_alu_op  (id_alu_op),
		.wb_valid   (wb_valid),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Writeback monitor

	// Sampled on the rising edge, before the DUT updates
	// A result held by ex_freeze is only counted once
	always @(posedge clk) begin
		if (rst_n && wb_valid && wb_new) begin
			wb_seen++;
			if (exp_rd_q.size() == 0) begin
				$display("unexpected writeback to r%0d", wb_rd);
				errors++;
			end else begin
				exp_rd = exp_rd_q.pop_front();
				exp_data = exp_data_q.pop_front();
				if (wb_rd !== exp_rd) begin
					$display("mismatch wb_rd: expected 0x%0h, got 0x%0h", exp_rd, wb_rd);
					errors++;
				end
				if (wb_data !== exp_data) begin
					$display("mismatch wb_data: expected 0x%08h, got 0x%08h",
						exp_data, wb_data);
					errors++;
				end
			end
		end
		wb_new = rst_n && !ex_freeze;
	end

	////////////////////////////////////////////////////////////////////////////
	// Model and stimulus helpers

	// Random register other than r0
	function automatic logic [`OP_REG_AW-1:0] rand_reg();
		return `OP_REG_AW'({$random(seed)} % 31 + 1);
	endfunction

	function automatic logic [`OP_WIDTH-1:0] rand_word();
		return $random(seed);
	endfunction

	// ALU reference
	// Shifts use the low five bits of b
	function automatic logic [`OP_WIDTH-1:0] alu_model(input alu_op_t op,
		input logic [`OP_WIDTH-1:0] a, input logic [`OP_WIDTH-1:0] b);
		case (op)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_AND: return a & b;
			ALU_OR:  return a | b;
			ALU_XOR: return a ^ b;
			ALU_SLL: return a << b[4:0];
			ALU_SRL: return a >> b[4:0];
			default: return '0;
		endcase
	endfunction

	// Present one instruction at the next falling edge
	// The model runs in program order and forwarding makes the DUT match it
	task automatic issue(input alu_op_t op, input logic [`OP_REG_AW-1:0] rs_a,
		input logic [`OP_REG_AW-1:0] rs_b, input logic [`OP_REG_AW-1:0] rd,
		input logic [`OP_WIDTH-1:0] imm, input logic use_imm);
		logic [`OP_WIDTH-1:0] b;
		logic [`OP_WIDTH-1:0] result;
		@(negedge clk);
		id_valid = 1'b1;
		id_alu_op = op;
		id_rs_a = rs_a;
		id_rs_b = rs_b;
		id_rd = rd;
		id_imm = imm;
		id_use_imm = use_imm;
		b = use_imm ? imm : model_regs[rs_b];
		result = alu_model(op, model_regs[rs_a], b);
		exp_rd_q.push_back(rd);
		exp_data_q.push_back(result);
		if (rd != '0) begin
			model_regs[rd] = result;
		end
	endtask

	// Stop issuing and wait for every pending writeback
	task automatic drain();
		int cycles;
		cycles = 0;
		@(negedge clk);
		id_valid = 1'b0;
		while (exp_rd_q.size() != 0 && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			cycles++;
		end
		if (exp_rd_q.size() != 0) begin
			$display("timeout with %0d writebacks still pending", exp_rd_q.size());
			errors++;
			exp_rd_q.delete();
			exp_data_q.delete();
		end
	endtask

	task automatic report_test(input string name, input int start_errors);
		tests_run++;
		if (errors == start_errors) begin
			$display("test %s: pass", name);
		end else begin
			$display("test %s: FAIL with %0d errors", name, errors - start_errors);
			tests_failing++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests

	// r0 + r0 after reset then immediate loads read back through the RF
	task automatic reset_regfile_test();
		int edges;
		issue(ALU_ADD, 5'd0, 5'd0, 5'd3, '0, 1'b0);
		edges = 0;
		do begin
			@(negedge clk);
			id_valid = 1'b0;
			edges++;
		end while (!wb_valid && edges < TIMEOUT_CYCLES);
		if (!wb_valid) begin
			$display("timeout waiting for wb_valid after the first add");
			errors++;
		end else if (edges != 2) begin
			$display("wb_valid came %0d edges after issue instead of 2", edges);
			errors++;
		end
		drain();
		for (int i = 0; i < 6; i++) begin
			issue(ALU_ADD, 5'd0, 5'd0, 5'(i * 5 + 1), rand_word(), 1'b1);
		end
		drain();
		// Reads land after the loads are in the register file
		for (int i = 0; i < 6; i++) begin
			issue(ALU_OR, 5'(i * 5 + 1), 5'd0, 5'(i * 5 + 2), '0, 1'b0);
		end
		drain();
	endtask

	// Every opcode on register and immediate operands
	task automatic alu_ops_test();
		logic [`OP_REG_AW-1:0] ra;
		logic [`OP_REG_AW-1:0] rb;
		logic [`OP_REG_AW-1:0] rd;
		logic [`OP_WIDTH-1:0]  imm;
		for (int r = 1; r < `OP_REG_COUNT; r++) begin
			imm = rand_word();
			issue(ALU_ADD, 5'd0, 5'd0, 5'(r), imm, 1'b1);
		end
		for (int k = 0; k < 7; k++) begin
			for (int n = 0; n < 8; n++) begin
				ra = rand_reg();
				rb = rand_reg();
				rd = rand_reg();
				imm = rand_word();
				issue(alu_op_t'(k), ra, rb, rd, imm, n[0]);
			end
		end
		drain();
	endtask

	// Each instruction reads the one just before it
	task automatic exec_forward_test();
		logic [`OP_REG_AW-1:0] prev;
		logic [`OP_REG_AW-1:0] next;
		logic [`OP_REG_AW-1:0] other;
		prev = rand_reg();
		issue(ALU_ADD, 5'd0, 5'd0, prev, rand_word(), 1'b1);
		for (int i = 0; i < 10; i++) begin
			next = rand_reg();
			other = rand_reg();
			// Odd steps forward both operands
			issue(alu_op_t'(i % 7), prev, i[0] ? prev : other, next, '0, 1'b0);
			prev = next;
		end
		drain();
	endtask

	// Two-ahead sources, same target in both stages, and r0 targets
	task automatic wb_forward_test();
		issue(ALU_ADD, 5'd0, 5'd0, 5'd7, rand_word(), 1'b1);
		issue(ALU_XOR, 5'd2, 5'd3, 5'd9, '0, 1'b0);
		issue(ALU_ADD, 5'd7, 5'd7, 5'd10, '0, 1'b0);
		// Newer r8 sits in execute and the older one in writeback
		issue(ALU_ADD, 5'd0, 5'd0, 5'd8, rand_word(), 1'b1);
		issue(ALU_ADD, 5'd0, 5'd0, 5'd8, rand_word(), 1'b1);
		issue(ALU_OR, 5'd8, 5'd0, 5'd12, '0, 1'b0);
		issue(ALU_ADD, 5'd0, 5'd8, 5'd13, '0, 1'b0);
		// Result aimed at r0 must not be forwarded or stored
		issue(ALU_ADD, 5'd0, 5'd0, 5'd0, 32'hdead_beef, 1'b1);
		issue(ALU_OR, 5'd0, 5'd0, 5'd14, '0, 1'b0);
		issue(ALU_ADD, 5'd0, 5'd0, 5'd15, '0, 1'b0);
		drain();
		issue(ALU_OR, 5'd0, 5'd0, 5'd16, '0, 1'b0);
		drain();
	endtask

	// Consumer frozen in decode while its producer sits in execute
	task automatic decode_freeze_test();
		int start_seen;
		issue(ALU_ADD, 5'd0, 5'd0, 5'd5, rand_word(), 1'b1);
		issue(ALU_XOR, 5'd5, 5'd2, 5'd6, '0, 1'b0);
		id_freeze = 1'b1;
		start_seen = wb_seen;
		repeat (4) @(negedge clk);
		// Only the producer drains out
		if (wb_seen - start_seen != 1) begin
			$display("%0d writebacks during decode freeze, only the producer expected",
				wb_seen - start_seen);
			errors++;
		end
		id_freeze = 1'b0;
		drain();
		if (wb_seen - start_seen != 2) begin
			$display("held instruction wrote back %0d times instead of once",
				wb_seen - start_seen - 1);
			errors++;
		end
	endtask

	// Both freezes mid-stream
	// Writeback keeps the oldest instruction of the stream
	task automatic full_freeze_test();
		logic [`OP_REG_AW-1:0] first_rd;
		logic [`OP_WIDTH-1:0]  first_data;
		logic [`OP_REG_AW-1:0] prev;
		logic [`OP_REG_AW-1:0] next;
		logic [`OP_REG_AW-1:0] other;
		prev = 5'd4;
		first_rd = '0;
		first_data = '0;
		for (int i = 0; i < 6; i++) begin
			next = rand_reg();
			other = rand_reg();
			issue(alu_op_t'(i), prev, other, next, '0, 1'b0);
			prev = next;
			if (i == 0) begin
				first_rd = next;
				first_data = model_regs[next];
			end
			if (i == 2) begin
				id_freeze = 1'b1;
				ex_freeze = 1'b1;
				repeat (4) begin
					@(negedge clk);
					if (wb_valid !== 1'b1) begin
						$display("mismatch wb_valid in freeze: expected 0x%0h, got 0x%0h",
							1'b1, wb_valid);
						errors++;
					end
					if (wb_rd !== first_rd) begin
						$display("mismatch wb_rd in freeze: expected 0x%0h, got 0x%0h",
							first_rd, wb_rd);
						errors++;
					end
					if (wb_data !== first_data) begin
						$display("mismatch wb_data in freeze: expected 0x%08h, got 0x%08h",
							first_data, wb_data);
						errors++;
					end
				end
				id_freeze = 1'b0;
				ex_freeze = 1'b0;
			end
		end
		drain();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		int start;
		seed = 32'h5c77a87b;
		errors = 0;
		tests_run = 0;
		tests_failing = 0;
		wb_seen = 0;
		wb_new = 1'b0;
		rst_n = 1'b0;
		id_freeze = 1'b0;
		ex_freeze = 1'b0;
		id_valid = 1'b0;
		id_rs_a = '0;
		id_rs_b = '0;
		id_rd = '0;
		id_imm = '0;
		id_use_imm = 1'b0;
		id_alu_op = ALU_ADD;
		for (int r = 0; r < `OP_REG_COUNT; r++) begin
			model_regs[r] = '0;
		end
		repeat (16) @(negedge clk);
		rst_n = 1'b1;

		start = errors;
		reset_regfile_test();
		report_test("reset_regfile", start);
		start = errors;
		alu_ops_test();
		report_test("alu_ops", start);
		start = errors;
		exec_forward_test();
		report_test("exec_forward", start);
		start = errors;
		wb_forward_test();
		report_test("wb_forward", start);
		start = errors;
		decode_freeze_test();
		report_test("decode_freeze", start);
		start = errors;
		full_freeze_test();
		report_test("full_freeze", start);

		// Bound checks count toward the total
		errors += dut.u_assertions.fail_count;
		$display("%0d tests run, %0d failing, %0d errors", tests_run, tests_failing, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
